/* logic/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath widths
`define EXEC_WORD_W 32
`define EXEC_IR_W 64

// extra cycles the integer unit holds the stage
// up to 15 for the 4-bit stall counter
`define EXEC_INT_STALL 4

// vector base after reset
`define EXEC_VECT_RESET 32'hffffffc0

`endif

/* logic/exec_pkg.sv */
`include "exec_params.svh"

package exec_pkg;

  typedef logic [`EXEC_WORD_W-1:0] word_t;
  typedef logic [`EXEC_IR_W-1:0] instr_t;  // upper half is the extension word
  typedef logic [2:0] ccr_t;  // {ltu, lt, eq}
  typedef logic [3:0] bank_t;
  typedef logic [1:0] regwr_t;
  typedef logic [2:0] irq_t;

  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_INT    = 4'h1,
    T_INTU   = 4'h2,
    T_ALU    = 4'h3,
    T_CMP    = 4'h4,
    T_LOAD   = 4'h5,
    T_STORE  = 4'h6,
    T_LDI    = 4'h7,
    T_MOV    = 4'h8,
    T_BRANCH = 4'h9,
    T_JUMP   = 4'ha
  } instr_type_e;

  typedef enum logic [2:0] {
    ALU_AND,
    ALU_OR,
    ALU_ADD,
    ALU_SUB,
    ALU_LSHIFT,
    ALU_RSHIFTA,
    ALU_RSHIFTL,
    ALU_XOR
  } alu_func_e;

  // bit 2 selects the unsigned forms
  typedef enum logic [3:0] {
    INT_MUL   = 4'h0,
    INT_DIV   = 4'h1,
    INT_MOD   = 4'h2,
    INT_SPARE = 4'h3,
    INT_MULU  = 4'h4,
    INT_DIVU  = 4'h5,
    INT_MODU  = 4'h6
  } int_func_e;

  typedef struct packed {
    instr_t ir;
    word_t  pc;
    word_t  rd1;
    word_t  rd2;
    regwr_t reg_write;
    bank_t  bank;
  } exec_in_t;

  typedef struct packed {
    instr_t ir;
    word_t  pc;
    word_t  rd1;
    word_t  result;
    regwr_t reg_write;
    bank_t  bank;
  } exec_out_t;

endpackage

/* logic/alu_comb.sv */
`timescale 1ns/1ps

module alu_comb (
  input  exec_pkg::word_t     in1_i,
  input  exec_pkg::word_t     in2_i,
  input  exec_pkg::alu_func_e func_i,
  output exec_pkg::word_t     out_o,
  output logic                c_o,
  output logic                z_o,
  output logic                n_o,
  output logic                v_o
);

  logic [32:0] sum;  // carry out in bit 32
  logic [32:0] diff;  // borrow in bit 32

  assign sum = {1'b0, in1_i} + {1'b0, in2_i};
  assign diff = {1'b0, in1_i} - {1'b0, in2_i};

  always_comb
  begin
    out_o = '0;
    c_o = 1'b0;
    v_o = 1'b0;
    case (func_i)
      exec_pkg::ALU_AND: out_o = in1_i & in2_i;
      exec_pkg::ALU_OR: out_o = in1_i | in2_i;
      exec_pkg::ALU_ADD:
      begin
        out_o = sum[31:0];
        c_o = sum[32];
        v_o = (in1_i[31] == in2_i[31]) && (sum[31] != in1_i[31]);
      end
      exec_pkg::ALU_SUB:
      begin
        out_o = diff[31:0];
        c_o = diff[32];  // set when in1 < in2 unsigned
        v_o = (in1_i[31] != in2_i[31]) && (diff[31] != in1_i[31]);
      end
      exec_pkg::ALU_LSHIFT: out_o = in1_i << in2_i[4:0];
      exec_pkg::ALU_RSHIFTA: out_o = $signed(in1_i) >>> in2_i[4:0];
      exec_pkg::ALU_RSHIFTL: out_o = in1_i >> in2_i[4:0];
      exec_pkg::ALU_XOR: out_o = in1_i ^ in2_i;
      default:
      begin
      end
    endcase
  end

  assign z_o = (out_o == '0);
  assign n_o = out_o[31];

endmodule

/* logic/int_calc.sv */
`timescale 1ns/1ps

module int_calc (
  input  exec_pkg::int_func_e func_i,
  input  exec_pkg::word_t     in1_i,
  input  exec_pkg::word_t     in2_i,
  output exec_pkg::word_t     out_o
);

  logic div_zero;

  assign div_zero = (in2_i == '0);

  always_comb
  begin
    out_o = '0;  // spare codes
    case (func_i)
      exec_pkg::INT_MUL: out_o = $signed(in1_i) * $signed(in2_i);
      exec_pkg::INT_MULU: out_o = in1_i * in2_i;
      exec_pkg::INT_DIV:
        if (div_zero)
          out_o = '1;
        else
          out_o = $signed(in1_i) / $signed(in2_i);
      exec_pkg::INT_DIVU:
        if (div_zero)
          out_o = '1;
        else
          out_o = in1_i / in2_i;
      exec_pkg::INT_MOD:
        if (div_zero)
          out_o = in1_i;  // dividend passes through
        else
          out_o = $signed(in1_i) % $signed(in2_i);
      exec_pkg::INT_MODU:
        if (div_zero)
          out_o = in1_i;
        else
          out_o = in1_i % in2_i;
      default:
      begin
      end
    endcase
  end

endmodule

/* logic/exc_ctrl.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module exc_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  stall_i,
  input  exec_pkg::instr_type_e type_i,
  input  logic [3:0]            op_i,
  input  logic                  size_i,
  input  exec_pkg::word_t       ext_i,
  input  exec_pkg::bank_t       bank_i,
  input  exec_pkg::irq_t        irq_i,
  output exec_pkg::bank_t       bank_o,
  output logic                  take_irq_o,
  output logic                  exc_o,
  output logic                  halt_o,
  output logic                  supervisor_o,
  output logic                  int_en_o,
  output exec_pkg::word_t       vect_o
);

  logic            priv_op;
  logic            enter;  // exception entry this cycle
  logic            exc_next;
  logic            halt_next;
  logic            super_next;
  logic            int_en_next;
  exec_pkg::word_t vect_next;

  // setvect, cli, sti, reset and user
  assign priv_op = (type_i == exec_pkg::T_INH) &&
                   ((op_i == 4'h1 && size_i) || op_i == 4'h2 || op_i == 4'h3 ||
                    op_i == 4'h5 || op_i == 4'h6);
  assign take_irq_o = int_en_o && (|irq_i) && !stall_i;
  assign bank_o = enter ? bank_i + 4'h1 : bank_i;

  always_comb
  begin
    enter = 1'b0;
    exc_next = exc_o;
    halt_next = halt_o;
    super_next = supervisor_o;
    int_en_next = int_en_o;
    vect_next = vect_o;
    if (!stall_i)
    begin
      exc_next = 1'b0;
      if (take_irq_o)
        enter = 1'b1;
      else if (priv_op && !supervisor_o)
        halt_next = 1'b1;  // privilege violation
      else if (type_i == exec_pkg::T_INH)
      begin
        case (op_i)
          4'h1:
            if (size_i)
              vect_next = ext_i;  // set vector base
            else
              enter = 1'b1;  // trap
          4'h2: int_en_next = 1'b0;
          4'h3: int_en_next = 1'b1;
          4'h4: halt_next = 1'b1;
          4'h5: enter = 1'b1;
          4'h6: super_next = 1'b0;  // drop to user mode
          default:
          begin
          end
        endcase
      end
      if (enter)
      begin
        exc_next = 1'b1;
        int_en_next = 1'b0;
        super_next = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      exc_o <= 1'b0;
      halt_o <= 1'b0;
      supervisor_o <= 1'b1;
      int_en_o <= 1'b0;
      vect_o <= `EXEC_VECT_RESET;
    end
    else
    begin
      exc_o <= exc_next;
      halt_o <= halt_next;
      supervisor_o <= super_next;
      int_en_o <= int_en_next;
      vect_o <= vect_next;
    end
  end

endmodule

/* logic/execute.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module execute (
  input  logic                clk_i,
  input  logic                rst_i,
  input  exec_pkg::exec_in_t  stage_i,
  input  logic                stall_i,
  input  exec_pkg::irq_t      irq_i,
  output exec_pkg::exec_out_t stage_o,
  output exec_pkg::ccr_t      ccr_o,
  output logic                pc_set_o,
  output logic                stall_o,
  output logic                halt_o,
  output logic                exc_o,
  output logic                supervisor_o,
  output logic                int_en_o
);

  exec_pkg::instr_t      ir;
  exec_pkg::instr_type_e ir_type;
  logic [3:0]            ir_op;
  logic                  ir_size;
  exec_pkg::word_t       ir_ext;
  exec_pkg::word_t       ir_sval;
  exec_pkg::word_t       ir_uval;
  exec_pkg::word_t       ir_scaled;
  exec_pkg::word_t       alu_in1;
  exec_pkg::word_t       alu_in2;
  exec_pkg::word_t       alu_out;
  exec_pkg::word_t       int_out;
  exec_pkg::word_t       vect;
  exec_pkg::alu_func_e   alu_func;
  exec_pkg::int_func_e   int_func;
  logic                  alu_c;
  logic                  alu_z;
  logic                  alu_n;
  logic                  alu_v;
  logic                  hold;
  logic                  take_irq;
  logic                  br_taken;
  logic                  stall_start;
  logic [3:0]            delay;  // integer unit countdown
  exec_pkg::bank_t       bank_next;
  exec_pkg::exec_out_t   stage_next;
  exec_pkg::ccr_t        ccr_next;
  logic                  pc_set_next;

  assign ir = stage_i.ir;
  assign ir_type = exec_pkg::instr_type_e'(ir[31:28]);
  assign ir_op = ir[27:24];
  assign ir_size = ir[0];
  assign ir_ext = ir[63:32];
  assign ir_sval = {{17{ir[15]}}, ir[15:1]};
  assign ir_uval = {17'd0, ir[15:1]};
  assign ir_scaled = {ir_sval[29:0], 2'b00};  // word offset

  assign stall_start = (ir_type == exec_pkg::T_INT || ir_type == exec_pkg::T_INTU) &&
                       (delay == 4'd0);
  assign stall_o = stall_start || (delay > 4'd1);
  assign hold = stall_i || stall_o;

  // stops at 1 until downstream accepts the result
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      delay <= 4'd0;
    else if (stall_start)
      delay <= 4'(`EXEC_INT_STALL);
    else if (delay > 4'd1 || (delay == 4'd1 && !stall_i))
      delay <= delay - 4'd1;
  end

  always_comb
  begin
    alu_in1 = stage_i.rd1;
    alu_in2 = stage_i.rd2;
    alu_func = exec_pkg::alu_func_e'(ir_op[2:0]);
    int_func = exec_pkg::int_func_e'({1'b0, ir_type == exec_pkg::T_INTU, ir_op[1:0]});
    case (ir_type)
      exec_pkg::T_ALU, exec_pkg::T_INT, exec_pkg::T_INTU:
        if (ir_op[3])
          alu_in2 = ir_sval;  // immediate form
      exec_pkg::T_CMP: alu_func = exec_pkg::ALU_SUB;
      exec_pkg::T_LOAD, exec_pkg::T_STORE:
      begin
        alu_func = exec_pkg::ALU_ADD;
        alu_in1 = ir_scaled;
      end
      exec_pkg::T_BRANCH:
      begin
        alu_func = exec_pkg::ALU_ADD;
        alu_in1 = stage_i.pc;
        alu_in2 = ir_scaled;
      end
      exec_pkg::T_JUMP:
      begin
        alu_func = exec_pkg::ALU_ADD;
        alu_in2 = ir_scaled;
      end
      default:
      begin
      end
    endcase
  end

  always_comb
  begin
    case (ir_op)
      4'h0: br_taken = 1'b1;  // bra
      4'h1: br_taken = ccr_o[0];
      4'h2: br_taken = !ccr_o[0];
      4'h3: br_taken = !(ccr_o[2] || ccr_o[0]);  // bgtu
      4'h4: br_taken = !(ccr_o[1] || ccr_o[0]);
      4'h5: br_taken = !ccr_o[1];
      4'h6: br_taken = ccr_o[1] || ccr_o[0];
      4'h7: br_taken = ccr_o[1];
      4'h8: br_taken = !ccr_o[2];  // bgeu
      4'h9: br_taken = ccr_o[2];
      4'ha: br_taken = ccr_o[2] || ccr_o[0];
      default: br_taken = 1'b0;
    endcase
  end

  always_comb
  begin
    stage_next.ir = stage_i.ir;
    stage_next.pc = stage_i.pc;
    stage_next.rd1 = stage_i.rd1;
    stage_next.reg_write = stage_i.reg_write;
    stage_next.bank = bank_next;
    stage_next.result = alu_out;
    ccr_next = ccr_o;
    pc_set_next = 1'b0;
    if (take_irq)
      stage_next.result = vect + {26'd0, irq_i, 3'd0};
    else
    begin
      case (ir_type)
        exec_pkg::T_INH:
          if (ir_op == 4'h5)
            stage_next.result = vect;  // reset vector
          else if (ir_op == 4'h1 && !ir_size)
            stage_next.result = vect + 32'd24 + {27'd0, ir[2:1], 3'd0};
        exec_pkg::T_INT, exec_pkg::T_INTU: stage_next.result = int_out;
        exec_pkg::T_CMP: ccr_next = {alu_c, alu_n ^ alu_v, alu_z};
        exec_pkg::T_LOAD, exec_pkg::T_STORE:
          if (ir_size)
            stage_next.result = ir_ext;  // absolute address
        exec_pkg::T_LDI: stage_next.result = ir_size ? ir_ext : ir_uval;
        exec_pkg::T_MOV: stage_next.result = stage_i.rd1;
        exec_pkg::T_BRANCH:
          if (br_taken)
          begin
            stage_next.pc = alu_out;
            pc_set_next = 1'b1;
          end
        exec_pkg::T_JUMP:
        begin
          stage_next.pc = ir_size ? ir_ext : alu_out;
          pc_set_next = 1'b1;
        end
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      stage_o <= '0;
      ccr_o <= '0;
      pc_set_o <= 1'b0;
    end
    else if (!hold)
    begin
      stage_o <= stage_next;
      ccr_o <= ccr_next;
      pc_set_o <= pc_set_next;
    end
  end

  alu_comb u_alu (
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .func_i (alu_func),
    .out_o  (alu_out),
    .c_o    (alu_c),
    .z_o    (alu_z),
    .n_o    (alu_n),
    .v_o    (alu_v)
  );

  int_calc u_int (
    .func_i (int_func),
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .out_o  (int_out)
  );

  exc_ctrl u_exc (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (hold),
    .type_i       (ir_type),
    .op_i         (ir_op),
    .size_i       (ir_size),
    .ext_i        (ir_ext),
    .bank_i       (stage_i.bank),
    .irq_i        (irq_i),
    .bank_o       (bank_next),
    .take_irq_o   (take_irq),
    .exc_o        (exc_o),
    .halt_o       (halt_o),
    .supervisor_o (supervisor_o),
    .int_en_o     (int_en_o),
    .vect_o       (vect)
  );

endmodule

/* logic/exec_top.sv */
`timescale 1ns/1ps

module exec_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  exec_pkg::exec_in_t  stage_i,
  input  logic                stall_i,
  input  exec_pkg::irq_t      irq_i,
  output exec_pkg::exec_out_t stage_o,
  output exec_pkg::ccr_t      ccr_o,
  output logic                pc_set_o,
  output logic                halt_o,
  output logic                exc_o,
  output logic                stall_o,
  output logic                supervisor_o,
  output logic                int_en_o
);

  // pipeline ports map straight onto the stage
  execute u_execute (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stage_i      (stage_i),
    .stall_i      (stall_i),
    .irq_i        (irq_i),
    .stage_o      (stage_o),
    .ccr_o        (ccr_o),
    .pc_set_o     (pc_set_o),
    .stall_o      (stall_o),
    .halt_o       (halt_o),
    .exc_o        (exc_o),
    .supervisor_o (supervisor_o),
    .int_en_o     (int_en_o)
  );

endmodule

/* bench/exec_sva.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_sva (
  input logic                clk_i,
  input logic                rst_i,
  input logic                stall_i,
  input logic                stall_o,
  input exec_pkg::exec_in_t  stage_i,
  input exec_pkg::exec_out_t stage_o,
  input exec_pkg::ccr_t      ccr_o,
  input logic                pc_set_o,
  input logic                exc_o,
  input logic                halt_o
);

  logic exc_instr;  // trap or reset presented

  assign exc_instr = (stage_i.ir[31:28] == exec_pkg::T_INH) &&
                     ((stage_i.ir[27:24] == 4'h1 && !stage_i.ir[0]) ||
                      stage_i.ir[27:24] == 4'h5);

  stall_ends: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(stall_o) |-> ##(`EXEC_INT_STALL) !stall_o)
    else $error("integer stall ran past its count");

  stall_length: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(stall_o) |-> $past(stall_o, `EXEC_INT_STALL) &&
                       !$past(stall_o, `EXEC_INT_STALL + 1))
    else $error("integer stall had the wrong length");

  hold_outputs: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> $stable(stage_o) && $stable(ccr_o) && $stable(pc_set_o) &&
                $stable(exc_o) && $stable(halt_o))
    else $error("outputs moved under downstream stall");

  // interrupts are masked right after entry
  exc_single: assert property (@(posedge clk_i) disable iff (rst_i)
    exc_o && !stall_i && !stall_o && !exc_instr |=> !exc_o)
    else $error("exception strobe repeated without a new trap or reset");

  halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    halt_o |=> halt_o)
    else $error("halt cleared");

endmodule

bind execute exec_sva u_sva (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .stall_i  (stall_i),
  .stall_o  (stall_o),
  .stage_i  (stage_i),
  .stage_o  (stage_o),
  .ccr_o    (ccr_o),
  .pc_set_o (pc_set_o),
  .exc_o    (exc_o),
  .halt_o   (halt_o)
);

/* bench/exec_tb.sv */
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_tb;

  localparam int NUM_PATTERNS = 46;
  localparam int FIELDS = 10;  // words per pattern line
  localparam int CYCLE_LIMIT = NUM_PATTERNS * (`EXEC_INT_STALL + 2) + 50;

  logic                clk_i = 1'b0;
  logic                rst_i;
  exec_pkg::exec_in_t  stage_i;
  logic                stall_i;
  exec_pkg::irq_t      irq_i;
  exec_pkg::exec_out_t stage_o;
  exec_pkg::ccr_t      ccr_o;
  logic                pc_set_o;
  logic                halt_o;
  logic                exc_o;
  logic                stall_o;
  logic                supervisor_o;
  logic                int_en_o;

  exec_pkg::word_t pat_mem [0:NUM_PATTERNS*FIELDS-1];
  logic [31:0]     lfsr_q;
  int              cycles = 0;

  exec_top dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stage_i      (stage_i),
    .stall_i      (stall_i),
    .irq_i        (irq_i),
    .stage_o      (stage_o),
    .ccr_o        (ccr_o),
    .pc_set_o     (pc_set_o),
    .halt_o       (halt_o),
    .exc_o        (exc_o),
    .stall_o      (stall_o),
    .supervisor_o (supervisor_o),
    .int_en_o     (int_en_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: stage never released stall");
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic exec_pkg::word_t random_word();
    exec_pkg::word_t w;
    w = '0;
    for (int i = 0; i < 32; i++)
      w = {w[30:0], lfsr_bit()};
    return w;
  endfunction

  // register form add and subtract modulo 2^32
  function automatic exec_pkg::word_t expected_alu(input logic [3:0] op,
                                                   input exec_pkg::word_t a,
                                                   input exec_pkg::word_t b);
    exec_pkg::word_t r;
    if (op == 4'h3)
      r = a - b;
    else
      r = a + b;
    return r;
  endfunction

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic check_word(input string name, input exec_pkg::word_t got,
                            input exec_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_ccr(input string name, input exec_pkg::ccr_t got,
                           input exec_pkg::ccr_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s: got %b expected %b", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_bank(input string name, input exec_pkg::bank_t got,
                            input exec_pkg::bank_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s: got %b expected %b", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_reset_state();
    check_word("reset result", stage_o.result, '0);
    check_word("reset pc", stage_o.pc, '0);
    check_ccr("reset ccr", ccr_o, '0);
    check_bit("reset pc_set", pc_set_o, 1'b0);
    check_bit("reset halt", halt_o, 1'b0);
    check_bit("reset exc", exc_o, 1'b0);
    check_bit("reset stall", stall_o, 1'b0);
    check_bit("reset int_en", int_en_o, 1'b0);
    check_bit("reset supervisor", supervisor_o, 1'b1);
  endtask

  // inputs stay put while the integer unit holds the stage
  task automatic wait_release();
    #1;
    while (stall_o)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  initial
  begin
    exec_pkg::word_t f [0:FIELDS-1];
    exec_pkg::word_t exp_result;
    exec_pkg::word_t exp_pc;
    exec_pkg::word_t flags;
    exec_pkg::bank_t exp_bank;
    rst_i = 1'b1;
    stall_i = 1'b0;
    irq_i = '0;
    stage_i = '0;
    exp_bank = '0;
    lfsr_q = 32'd98724;
    $readmemh("bench/exec_patterns.txt", pat_mem);
    repeat (10) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_reset_state();
    for (int p = 0; p < NUM_PATTERNS; p++)
    begin
      for (int k = 0; k < FIELDS; k++)
        f[k] = pat_mem[p*FIELDS+k];
      stage_i.ir = {f[0], f[1]};
      stage_i.pc = f[2];
      stage_i.rd1 = f[3];
      stage_i.rd2 = f[4];
      stage_i.reg_write = f[5][5:4];
      stage_i.bank = f[5][3:0];
      stall_i = f[5][8];
      irq_i = f[6][2:0];
      exp_result = f[7];
      exp_pc = f[8];
      flags = f[9];
      if (flags[20])
      begin
        stage_i.rd1 = random_word();
        stage_i.rd2 = random_word();
        exp_result = expected_alu(f[1][27:24], stage_i.rd1, stage_i.rd2);
      end
      // exception entry moves to the next bank
      if (!stall_i)
        exp_bank = exec_pkg::bank_t'(stage_i.bank + {3'd0, flags[8]});
      wait_release();
      @(posedge clk_i);
      #1;
      check_word("result", stage_o.result, exp_result);
      check_word("pc", stage_o.pc, exp_pc);
      check_bank("bank", stage_o.bank, exp_bank);
      check_bit("pc_set", pc_set_o, flags[16]);
      check_ccr("ccr", ccr_o, flags[14:12]);
      check_bit("exc", exc_o, flags[8]);
      check_bit("halt", halt_o, flags[4]);
      check_bit("int_en", int_en_o, flags[0]);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* bench/exec_patterns.txt */
// ir_hi ir_lo pc rd1 rd2 ctl(stall,regwr,bank) irq result pc
// flags nibbles: random_operands pc_set ccr exc halt int_en
00000000 32000000 00000100 00000000 00000000 010 0 00000000 00000100 100000
00000000 33000000 00000104 00000000 00000000 010 0 00000000 00000104 100000
00000000 380001fe 00000108 12345678 00000000 010 0 00000078 00000108 000000
00000000 37000000 0000010c f0f0f0f0 ff00ff00 010 0 0ff00ff0 0000010c 000000
00000000 3c000008 00000110 00000011 00000000 010 0 00000110 00000110 000000
00000000 7000fffe 00000114 00000000 00000000 010 0 00007fff 00000114 000000
deadbeef 70000001 00000118 00000000 00000000 010 0 deadbeef 00000118 000000
00000000 80000000 0000011c cafef00d 00000000 010 0 cafef00d 0000011c 000000
00000000 5000fffc 00000120 00000000 00001000 010 0 00000ff8 00000120 000000
00002000 60000001 00000124 00000000 00000000 010 0 00002000 00000124 000000
00000000 40000000 00000128 00000005 00000005 010 0 00000000 00000128 001000
00000000 91000008 0000012c 00000000 00000000 010 0 0000013c 0000013c 011000
00000000 92000008 00000130 00000000 00000000 010 0 00000140 00000130 001000
00000000 95000008 00000134 00000000 00000000 010 0 00000144 00000144 011000
00000000 97000008 00000138 00000000 00000000 010 0 00000148 00000138 001000
00000000 40000000 0000013c 00000003 00000005 010 0 fffffffe 0000013c 006000
00000000 99000008 00000140 00000000 00000000 010 0 00000150 00000150 016000
00000000 93000008 00000144 00000000 00000000 010 0 00000154 00000144 006000
00000000 9a000008 00000148 00000000 00000000 010 0 00000158 00000158 016000
00000000 96000008 0000014c 00000000 00000000 010 0 0000015c 0000015c 016000
00000000 40000000 00000150 ffffffff 00000001 010 0 fffffffe 00000150 002000
00000000 94000008 00000154 00000000 00000000 010 0 00000164 00000154 002000
00000000 98000008 00000158 00000000 00000000 010 0 00000168 00000168 012000
00000000 90000008 0000015c 00000000 00000000 010 0 0000016c 0000016c 012000
00000000 a0000008 00000160 00004000 00000000 010 0 00004010 00004010 012000
00008000 a0000001 00000164 00000000 00000000 010 0 00000000 00008000 012000
00000000 10000000 00000168 fffffffd 00000007 010 0 ffffffeb 00000168 002000
00000000 1900fff8 0000016c 00000064 00000000 010 0 ffffffe7 0000016c 002000
00000000 21000000 00000170 12345678 00000000 010 0 ffffffff 00000170 002000
00000000 22000000 00000174 00000064 00000007 010 0 00000002 00000174 002000
00000000 12000000 00000178 abcd0123 00000000 010 0 abcd0123 00000178 002000
00000000 03000000 0000017c 00000000 00000000 010 0 00000000 0000017c 002001
00000000 02000000 00000180 00000000 00000000 010 0 00000000 00000180 002000
00000000 00000000 00000184 00000000 00000000 010 3 00000000 00000184 002000
00000000 03000000 00000188 00000000 00000000 010 0 00000000 00000188 002001
00000000 00000000 0000018c 00000000 00000000 010 6 fffffff0 0000018c 002100
00000000 00000000 00000190 00000000 00000000 010 6 00000000 00000190 002000
00000000 01000004 00000194 00000000 00000000 010 0 ffffffe8 00000194 002100
00001000 01000001 00000198 00000000 00000000 010 0 00000000 00000198 002000
00000000 01000002 0000019c 00000000 00000000 010 0 00001020 0000019c 002100
00000000 80000000 000001a0 11111111 00000000 110 0 00001020 0000019c 002100
00000000 80000000 000001a0 11111111 00000000 010 0 11111111 000001a0 002000
00000000 06000000 000001a4 00000000 00000000 010 0 00000000 000001a4 002000
00000000 02000000 000001a8 00000000 00000000 010 0 00000000 000001a8 002010
00000000 80000000 000001ac 22222222 00000000 010 0 22222222 000001ac 002010
00000000 04000000 000001b0 00000000 00000000 010 0 00000000 000001b0 002010

/* filelist.f */
+incdir+logic
logic/exec_pkg.sv
logic/alu_comb.sv
logic/int_calc.sv
logic/exc_ctrl.sv
logic/execute.sv
logic/exec_top.sv
bench/exec_sva.sv
bench/exec_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module exec_tb -o exec_sim &&
  ./obj_dir/exec_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
